// ==== vlog.f ====
rtl/fp_alu_pkg.sv
rtl/fp_operand_unpack.sv
rtl/fp_align_shift.sv
rtl/fp_add_multiply.sv
rtl/fp_normalize_pack.sv
rtl/multi_cycle_scalar_alu.sv
tests/multi_cycle_alu_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the pipeline testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f vlog.f --top-module multi_cycle_alu_tb \
	-o multi_cycle_alu_tb_sim
./obj_dir/multi_cycle_alu_tb_sim > sim.log 2>&1
cat sim.log
if grep -q "FAIL: see errors above" sim.log; then
	echo "simulation reported failures"
	exit 1
fi
echo "simulation finished without failures"

// ==== tests/multi_cycle_alu_tb.sv ====
// Testbench for the four-stage scalar arithmetic pipeline
// Issues a table of operations back to back, one per clock
// Scoreboard checks each result three falling edges after issue
`timescale 1ns/1ps
`default_nettype none

module multi_cycle_alu_tb;
	import fp_alu_pkg::*;

	localparam int LATENCY = 3;	// Falling edges from drive to check
	localparam int RESET_CYCLES = 8;
	localparam int DRAIN_LIMIT = 10;	// Cycles allowed to empty the scoreboard
	localparam int RANDOM_IMUL_COUNT = 8;

	logic clk;
	logic reset;
	alu_op_t operation;
	logic [31:0] operand1;
	logic [31:0] operand2;
	wire [31:0] result;

	// One queue per column of the stimulus table
	string name_q[$];
	alu_op_t op_q[$];
	logic [31:0] a_q[$];
	logic [31:0] b_q[$];
	logic [31:0] expected_q[$];

	// Scoreboard of issued entries
	int pending_idx_q[$];
	int pending_cycle_q[$];

	int cycle;
	int pass_count;
	int fail_count;

	multi_cycle_scalar_alu i_dut (
		.clk(clk),
		.reset(reset),
		.operation_i(operation),
		.operand1_i(operand1),
		.operand2_i(operand2),
		.result_o(result)
	);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;	// 100 ns period
	end

	task automatic add_entry(input string name, input alu_op_t op, input logic [31:0] a,
		input logic [31:0] b, input logic [31:0] expected);
		name_q.push_back(name);
		op_q.push_back(op);
		a_q.push_back(a);
		b_q.push_back(b);
		expected_q.push_back(expected);
	endtask

	// Exact IEEE values that need no truncation
	task automatic build_table();
		logic [31:0] ra;
		logic [31:0] rb;
		logic [31:0] prod;
		add_entry("fadd_1p5_2p25", OP_FADD, 32'h3fc00000, 32'h40100000, 32'h40700000);
		add_entry("fmul_1p5_neg2", OP_FMUL, 32'h3fc00000, 32'hc0000000, 32'hc0400000);
		add_entry("imul_7x6", OP_IMUL, 32'd7, 32'd6, 32'd42);
		add_entry("fgtr_2_1", OP_FGTR, 32'h40000000, 32'h3f800000, 32'd1);
		add_entry("fsub_1_1", OP_FSUB, 32'h3f800000, 32'h3f800000, 32'h00000000);
		add_entry("fmul_inf_zero", OP_FMUL, 32'h7f800000, 32'h00000000, 32'hffffffff);
		add_entry("flt_1_2", OP_FLT, 32'h3f800000, 32'h40000000, 32'd1);
		add_entry("nop_idle", OP_NOP, 32'h12345678, 32'h9abcdef0, 32'h00000000);	// Idle slot
		add_entry("fsub_2_3", OP_FSUB, 32'h40000000, 32'h40400000, 32'hbf800000);
		add_entry("imul_wrap", OP_IMUL, 32'hffffffff, 32'd2, 32'hfffffffe);
		add_entry("fgtr_1_2", OP_FGTR, 32'h3f800000, 32'h40000000, 32'd0);
		add_entry("fadd_far_apart", OP_FADD, 32'h4f800000, 32'h3f800000, 32'h4f800000);
		add_entry("fmul_by_one", OP_FMUL, 32'h40490fdb, 32'h3f800000, 32'h40490fdb);
		add_entry("fgte_equal", OP_FGTE, 32'h40400000, 32'h40400000, 32'd1);
		add_entry("fmul_1p5_sq", OP_FMUL, 32'h3fc00000, 32'h3fc00000, 32'h40100000);
		add_entry("flte_equal", OP_FLTE, 32'h40400000, 32'h40400000, 32'd1);
		add_entry("fmul_overflow_pos", OP_FMUL, 32'h7f000000, 32'h40000000, 32'h7f800000);
		add_entry("fgtr_equal", OP_FGTR, 32'h40400000, 32'h40400000, 32'd0);
		add_entry("fmul_overflow_neg", OP_FMUL, 32'hff000000, 32'h40000000, 32'hff800000);
		add_entry("flt_equal", OP_FLT, 32'h40400000, 32'h40400000, 32'd0);
		add_entry("fmul_denormal", OP_FMUL, 32'h00400000, 32'h40000000, 32'h00000000);
		add_entry("fadd_denormal", OP_FADD, 32'h00400000, 32'h00400000, 32'h00000000);
		add_entry("fgtr_neg_pos", OP_FGTR, 32'hbf800000, 32'h40000000, 32'd0);
		add_entry("flt_neg_pos", OP_FLT, 32'hbf800000, 32'h40000000, 32'd1);
		add_entry("fgte_pos_neg", OP_FGTE, 32'h3fc00000, 32'hc0100000, 32'd1);
		add_entry("flte_pos_neg", OP_FLTE, 32'h3fc00000, 32'hc0100000, 32'd0);
		add_entry("flte_neg_neg", OP_FLTE, 32'hc0000000, 32'hbf800000, 32'd1);
		add_entry("fgte_neg_neg", OP_FGTE, 32'hc0000000, 32'hbf800000, 32'd0);
		add_entry("imul_high_drop", OP_IMUL, 32'h00010000, 32'h00010000, 32'h00000000);
		add_entry("fgte_signed_zero", OP_FGTE, 32'h00000000, 32'h80000000, 32'd1);
		for (int n = 0; n < RANDOM_IMUL_COUNT; n++)
		begin
			ra = $urandom();
			rb = $urandom();
			prod = ra * rb;	// Low word of the product
			add_entry($sformatf("imul_random_%0d", n), OP_IMUL, ra, rb, prod);
		end
	endtask

	task automatic compare_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual, output bit ok);
		ok = (actual === expected);
		if (!ok)
			$display("CHECK FAILED %s: expected %08h, actual %08h", name, expected, actual);
	endtask

	task automatic finish_test(input string name, input bit ok);
		if (ok)
			pass_count++;
		else
			fail_count++;
		$display("test %-20s %s", name, ok ? "ok" : "failed");
	endtask

	// Retire the oldest entry once its result is due
	task automatic retire_due();
		int idx;
		bit ok;
		while (pending_idx_q.size() != 0 && cycle - pending_cycle_q[0] == LATENCY)
		begin
			idx = pending_idx_q.pop_front();
			pending_cycle_q.delete(0);
			compare_value(name_q[idx], expected_q[idx], result, ok);
			finish_test(name_q[idx], ok);
		end
	endtask

	initial
	begin
		int waited;
		bit ok;
		bit all_ok;
		reset = 1'b1;
		operation = OP_NOP;
		operand1 = '0;
		operand2 = '0;
		cycle = 0;
		pass_count = 0;
		fail_count = 0;
		void'($urandom(32'he635));
		build_table();

		// Pipeline holds no-ops throughout reset
		all_ok = 1'b1;
		for (int n = 0; n < RESET_CYCLES; n++)
		begin
			@(negedge clk);
			compare_value("reset_hold", 32'h0, result, ok);
			all_ok &= ok;
		end
		finish_test("reset_hold", all_ok);
		reset = 1'b0;	// Released on a falling edge
		@(negedge clk);
		compare_value("reset_release", 32'h0, result, ok);
		finish_test("reset_release", ok);

		// Back to back issue keeps three entries in flight
		for (int idx = 0; idx < name_q.size(); idx++)
		begin
			@(negedge clk);
			cycle++;
			retire_due();
			operation = op_q[idx];
			operand1 = a_q[idx];
			operand2 = b_q[idx];
			pending_idx_q.push_back(idx);
			pending_cycle_q.push_back(cycle);
		end

		waited = 0;
		while (pending_idx_q.size() != 0 && waited < DRAIN_LIMIT)
		begin
			@(negedge clk);
			cycle++;
			waited++;
			operation = OP_NOP;	// Idle slots behind the table
			operand1 = '0;
			operand2 = '0;
			retire_due();
		end
		if (pending_idx_q.size() != 0)
		begin
			$display("ERROR: timed out after %0d cycles, %0d results never checked",
				DRAIN_LIMIT, pending_idx_q.size());
			fail_count++;
		end

		$display("tests passed: %0d, tests failed: %0d", pass_count, fail_count);
		if (fail_count == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

`default_nettype wire

// ==== rtl/multi_cycle_scalar_alu.sv ====
// Four-stage scalar arithmetic pipeline
// Float add, subtract, multiply and compare plus integer multiply
// Three register stages, last stage combinational
`timescale 1ns/1ps
`default_nettype none

module multi_cycle_scalar_alu (
	input wire clk,
	input wire reset,
	input wire fp_alu_pkg::alu_op_t operation_i,
	input wire [31:0] operand1_i,
	input wire [31:0] operand2_i,
	output wire [31:0] result_o
);
	import fp_alu_pkg::*;

	// Stage 1 outputs
	alu_op_t s1_op;
	logic [ALIGN_WIDTH - 1:0] s1_sig_large;
	logic [ALIGN_WIDTH - 1:0] s1_sig_small;
	logic [EXP_WIDTH - 1:0] s1_exp_large;
	logic [4:0] s1_shift;
	logic s1_sign_large;
	logic s1_subtract;
	logic s1_result_negate;
	logic [31:0] s1_mul_a;
	logic [31:0] s1_mul_b;
	logic signed [EXP_WIDTH + 1:0] s1_mul_exp;
	logic s1_mul_sign;
	logic s1_is_nan;
	logic s1_is_inf;

	// Stage 2 outputs
	alu_op_t s2_op;
	logic [ALIGN_WIDTH - 1:0] s2_sig_large;
	logic [ALIGN_WIDTH - 1:0] s2_sig_small;
	logic [EXP_WIDTH - 1:0] s2_exp;
	logic s2_sign;
	logic s2_subtract;
	logic [31:0] s2_mul_a;
	logic [31:0] s2_mul_b;
	logic signed [EXP_WIDTH + 1:0] s2_mul_exp;
	logic s2_mul_sign;
	logic s2_is_nan;
	logic s2_is_inf;

	// Stage 3 outputs
	alu_op_t s3_op;
	logic [ALIGN_WIDTH:0] s3_sum;
	logic [EXP_WIDTH - 1:0] s3_sum_exp;
	logic s3_sum_sign;
	logic [63:0] s3_product;
	logic signed [EXP_WIDTH + 1:0] s3_mul_exp;
	logic s3_mul_sign;
	logic s3_is_nan;
	logic s3_is_inf;

	// Operand words enter as raw 32-bit buses
	fp_operand_unpack i_unpack (
		.operand1_i(operand1_i),
		.operand2_i(operand2_i),
		.*
	);

	fp_align_shift i_align (.*);

	fp_add_multiply i_add_mul (.*);

	fp_normalize_pack i_norm (.*);	// Combinational tail

endmodule

`default_nettype wire

// ==== rtl/fp_normalize_pack.sv ====
// Stage 4 of the scalar arithmetic pipeline, purely combinational
// Normalizes the adder or multiplier result and packs the IEEE word
// Also produces the integer product and comparison bits
`timescale 1ns/1ps
`default_nettype none

module fp_normalize_pack (
	input wire fp_alu_pkg::alu_op_t s3_op,
	input wire [fp_alu_pkg::ALIGN_WIDTH:0] s3_sum,
	input wire [fp_alu_pkg::EXP_WIDTH - 1:0] s3_sum_exp,
	input wire s3_sum_sign,
	input wire [63:0] s3_product,
	input wire signed [fp_alu_pkg::EXP_WIDTH + 1:0] s3_mul_exp,
	input wire s3_mul_sign,
	input wire s3_is_nan,
	input wire s3_is_inf,
	output logic [fp_alu_pkg::WORD_WIDTH - 1:0] result_o
);
	import fp_alu_pkg::*;

	logic [47:0] norm_in;	// Candidate significand, either path
	logic signed [EXP_WIDTH + 2:0] base_exp;
	logic [5:0] lead_pos;
	logic [47:0] norm_shifted;
	logic signed [EXP_WIDTH + 2:0] final_exp;
	logic res_sign;
	logic [WORD_WIDTH - 1:0] float_word;
	logic diff_zero;
	logic diff_neg;
	logic compare_bit;

	// Path select and exponent of bit 0 of norm_in
	always_comb
	begin
		if (s3_op == OP_FMUL)
		begin
			norm_in = s3_product[47:0];	// 1.x lands on bit 46
			base_exp = (EXP_WIDTH + 3)'(s3_mul_exp) - 11'sd46;
			res_sign = s3_mul_sign;
		end
		else
		begin
			norm_in = {s3_sum, 20'd0};	// Hidden bit lands on bit 45
			base_exp = $signed({3'b000, s3_sum_exp}) - 11'sd45;
			res_sign = s3_sum_sign;
		end
	end

	// Leading one search, highest set bit wins
	always_comb
	begin
		lead_pos = '0;
		for (int b = 0; b < 48; b++)
		begin
			if (norm_in[b])
				lead_pos = 6'(b);
		end
	end

	assign norm_shifted = norm_in << (6'd47 - lead_pos);	// Leading one to bit 47
	assign final_exp = base_exp + $signed({5'b00000, lead_pos});

	always_comb
	begin
		if (s3_is_nan)
			float_word = QNAN_WORD;
		else if (s3_is_inf)
			float_word = {res_sign, EXP_SPECIAL, {SIG_WIDTH{1'b0}}};
		else if (norm_in == '0 || final_exp <= 0)
			float_word = '0;	// Zero or underflow flush
		else if (int'(final_exp) >= int'(EXP_SPECIAL))
			float_word = {res_sign, EXP_SPECIAL, {SIG_WIDTH{1'b0}}};	// Overflow
		else
			float_word = {res_sign, final_exp[EXP_WIDTH - 1:0], norm_shifted[46:24]};	// Truncated
	end

	// Sign and zero of op1 - op2
	assign diff_zero = s3_sum == '0 && !s3_is_inf;
	assign diff_neg = s3_sum_sign && !diff_zero;

	always_comb
	begin
		case (s3_op)
			OP_FGTR: compare_bit = !diff_zero && !diff_neg;
			OP_FLT: compare_bit = diff_neg;
			OP_FGTE: compare_bit = !diff_neg;
			OP_FLTE: compare_bit = diff_zero || diff_neg;
			default: compare_bit = 1'b0;
		endcase
		if (s3_is_nan)
			compare_bit = 1'b0;	// Unordered compares false
	end

	always_comb
	begin
		if (s3_op == OP_IMUL)
			result_o = s3_product[WORD_WIDTH - 1:0];	// Low word only
		else if (is_compare_op(s3_op))
			result_o = {{(WORD_WIDTH - 1){1'b0}}, compare_bit};
		else if (s3_op == OP_NOP)
			result_o = '0;
		else
			result_o = float_word;
	end

	// Opcode carried through three registers must still decode
	always_comb
	begin
		op_defined: assert ($isunknown(s3_op) || s3_op inside {OP_NOP, OP_IMUL, OP_FADD,
			OP_FSUB, OP_FMUL, OP_FGTR, OP_FLT, OP_FGTE, OP_FLTE})
			else $error("undefined opcode %0h in last stage", s3_op);
	end

endmodule

`default_nettype wire

// ==== rtl/fp_add_multiply.sv ====
// Stage 3 of the scalar arithmetic pipeline
// Adds or subtracts aligned significands
// Forms one 32x32 product shared by integer and float multiply
`timescale 1ns/1ps
`default_nettype none

module fp_add_multiply (
	input wire clk,
	input wire reset,
	input wire fp_alu_pkg::alu_op_t s2_op,
	input wire [fp_alu_pkg::ALIGN_WIDTH - 1:0] s2_sig_large,
	input wire [fp_alu_pkg::ALIGN_WIDTH - 1:0] s2_sig_small,
	input wire [fp_alu_pkg::EXP_WIDTH - 1:0] s2_exp,
	input wire s2_sign,
	input wire s2_subtract,
	input wire [31:0] s2_mul_a,
	input wire [31:0] s2_mul_b,
	input wire signed [fp_alu_pkg::EXP_WIDTH + 1:0] s2_mul_exp,
	input wire s2_mul_sign,
	input wire s2_is_nan,
	input wire s2_is_inf,
	output fp_alu_pkg::alu_op_t s3_op,
	output logic [fp_alu_pkg::ALIGN_WIDTH:0] s3_sum,
	output logic [fp_alu_pkg::EXP_WIDTH - 1:0] s3_sum_exp,
	output logic s3_sum_sign,
	output logic [63:0] s3_product,
	output logic signed [fp_alu_pkg::EXP_WIDTH + 1:0] s3_mul_exp,
	output logic s3_mul_sign,
	output logic s3_is_nan,
	output logic s3_is_inf
);
	import fp_alu_pkg::*;

	logic [ALIGN_WIDTH:0] large_ext;
	logic [ALIGN_WIDTH:0] small_ext;
	logic [ALIGN_WIDTH:0] sum;

	assign large_ext = {1'b0, s2_sig_large};
	assign small_ext = {1'b0, s2_sig_small};

	// Ordered operands, so the difference is never negative
	assign sum = s2_subtract ? large_ext - small_ext : large_ext + small_ext;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			s3_op <= OP_NOP;
			{s3_sum, s3_sum_exp, s3_sum_sign, s3_product, s3_mul_exp, s3_mul_sign,
				s3_is_nan, s3_is_inf} <= '0;
		end
		else
		begin
			s3_op <= s2_op;
			s3_sum <= sum;
			s3_sum_exp <= s2_exp;
			s3_sum_sign <= s2_sign;
			s3_product <= 64'(s2_mul_a) * 64'(s2_mul_b);	// Low word for IMUL, 48 bits for FMUL
			s3_mul_exp <= s2_mul_exp;
			s3_mul_sign <= s2_mul_sign;
			s3_is_nan <= s2_is_nan;
			s3_is_inf <= s2_is_inf;
		end
	end

	// Magnitude ordering from stage 1 must survive alignment
	ordered_subtract: assert property (@(posedge clk) disable iff (reset)
		s2_subtract |-> s2_sig_large >= s2_sig_small)
		else $error("adder operands out of order on subtract");

endmodule

`default_nettype wire

// ==== rtl/fp_align_shift.sv ====
// Stage 2 of the scalar arithmetic pipeline
// Aligns the smaller adder significand to the larger exponent
`timescale 1ns/1ps
`default_nettype none

module fp_align_shift (
	input wire clk,
	input wire reset,
	input wire fp_alu_pkg::alu_op_t s1_op,
	input wire [fp_alu_pkg::ALIGN_WIDTH - 1:0] s1_sig_large,
	input wire [fp_alu_pkg::ALIGN_WIDTH - 1:0] s1_sig_small,
	input wire [fp_alu_pkg::EXP_WIDTH - 1:0] s1_exp_large,
	input wire [4:0] s1_shift,
	input wire s1_sign_large,
	input wire s1_subtract,
	input wire s1_result_negate,
	input wire [31:0] s1_mul_a,
	input wire [31:0] s1_mul_b,
	input wire signed [fp_alu_pkg::EXP_WIDTH + 1:0] s1_mul_exp,
	input wire s1_mul_sign,
	input wire s1_is_nan,
	input wire s1_is_inf,
	output fp_alu_pkg::alu_op_t s2_op,
	output logic [fp_alu_pkg::ALIGN_WIDTH - 1:0] s2_sig_large,
	output logic [fp_alu_pkg::ALIGN_WIDTH - 1:0] s2_sig_small,
	output logic [fp_alu_pkg::EXP_WIDTH - 1:0] s2_exp,
	output logic s2_sign,
	output logic s2_subtract,
	output logic [31:0] s2_mul_a,
	output logic [31:0] s2_mul_b,
	output logic signed [fp_alu_pkg::EXP_WIDTH + 1:0] s2_mul_exp,
	output logic s2_mul_sign,
	output logic s2_is_nan,
	output logic s2_is_inf
);
	import fp_alu_pkg::*;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			s2_op <= OP_NOP;
			{s2_sig_large, s2_sig_small, s2_exp, s2_sign, s2_subtract, s2_mul_a, s2_mul_b,
				s2_mul_exp, s2_mul_sign, s2_is_nan, s2_is_inf} <= '0;
		end
		else
		begin
			s2_op <= s1_op;
			s2_sig_large <= s1_sig_large;
			s2_sig_small <= s1_sig_small >> s1_shift;	// Guard bits catch the first shifted-out bits
			s2_exp <= s1_exp_large;
			s2_sign <= s1_sign_large ^ s1_result_negate;	// Effective sign of the result
			s2_subtract <= s1_subtract;
			s2_mul_a <= s1_mul_a;	// Multiplier inputs ride along
			s2_mul_b <= s1_mul_b;
			s2_mul_exp <= s1_mul_exp;
			s2_mul_sign <= s1_mul_sign;
			s2_is_nan <= s1_is_nan;
			s2_is_inf <= s1_is_inf;
		end
	end

	// Stage 1 saturates so a distant operand shifts out to zero
	shift_in_range: assert property (@(posedge clk) disable iff (reset)
		s1_shift <= ALIGN_SHIFT_MAX)
		else $error("alignment shift %0d exceeds saturation limit", s1_shift);

endmodule

`default_nettype wire

// ==== rtl/fp_operand_unpack.sv ====
// Stage 1 of the scalar arithmetic pipeline
// Unpacks operands, flushes denormals and flags NaN or infinity
// Orders adder operands by magnitude and prepares multiplier inputs
`timescale 1ns/1ps
`default_nettype none

module fp_operand_unpack (
	input wire clk,
	input wire reset,
	input wire fp_alu_pkg::alu_op_t operation_i,
	input wire fp_alu_pkg::operand_word_t operand1_i,
	input wire fp_alu_pkg::operand_word_t operand2_i,
	output fp_alu_pkg::alu_op_t s1_op,
	output logic [fp_alu_pkg::ALIGN_WIDTH - 1:0] s1_sig_large,
	output logic [fp_alu_pkg::ALIGN_WIDTH - 1:0] s1_sig_small,
	output logic [fp_alu_pkg::EXP_WIDTH - 1:0] s1_exp_large,
	output logic [4:0] s1_shift,
	output logic s1_sign_large,
	output logic s1_subtract,
	output logic s1_result_negate,
	output logic [31:0] s1_mul_a,
	output logic [31:0] s1_mul_b,
	output logic signed [fp_alu_pkg::EXP_WIDTH + 1:0] s1_mul_exp,
	output logic s1_mul_sign,
	output logic s1_is_nan,
	output logic s1_is_inf
);
	import fp_alu_pkg::*;

	logic [EXP_WIDTH - 1:0] exp1;
	logic [EXP_WIDTH - 1:0] exp2;
	logic [SIG_WIDTH:0] mant1;	// Hidden bit plus fraction
	logic [SIG_WIDTH:0] mant2;
	logic [ALIGN_WIDTH - 1:0] sig1;
	logic [ALIGN_WIDTH - 1:0] sig2;
	logic nan1;
	logic nan2;
	logic inf1;
	logic inf2;
	logic subtract_op;
	logic add_like;
	logic eff_sign2;
	logic swap;
	logic [EXP_WIDTH - 1:0] exp_diff;
	logic [4:0] shift_sat;
	logic signed [EXP_WIDTH + 1:0] mul_exp;
	logic add_nan;
	logic mul_nan;

	assign exp1 = operand1_i.f.exponent;
	assign exp2 = operand2_i.f.exponent;
	assign mant1 = (exp1 == '0) ? '0 : {1'b1, operand1_i.f.significand};	// Denormal flush
	assign mant2 = (exp2 == '0) ? '0 : {1'b1, operand2_i.f.significand};
	assign sig1 = {1'b0, mant1, 2'b00};
	assign sig2 = {1'b0, mant2, 2'b00};
	assign nan1 = exp1 == EXP_SPECIAL && operand1_i.f.significand != '0;
	assign nan2 = exp2 == EXP_SPECIAL && operand2_i.f.significand != '0;
	assign inf1 = exp1 == EXP_SPECIAL && operand1_i.f.significand == '0;
	assign inf2 = exp2 == EXP_SPECIAL && operand2_i.f.significand == '0;

	assign subtract_op = operation_i == OP_FSUB || is_compare_op(operation_i);
	assign add_like = operation_i == OP_FADD || subtract_op;
	assign eff_sign2 = operand2_i.f.sign ^ subtract_op;	// Subtract is add of negated op2

	// Magnitude order decides which significand gets aligned
	assign swap = {exp2, sig2} > {exp1, sig1};
	assign exp_diff = swap ? exp2 - exp1 : exp1 - exp2;
	assign shift_sat = (exp_diff > 8'(ALIGN_SHIFT_MAX)) ? ALIGN_SHIFT_MAX : exp_diff[4:0];

	assign add_nan = nan1 | nan2 | (inf1 & inf2 & (operand1_i.f.sign ^ eff_sign2));	// Inf - inf
	assign mul_nan = nan1 | nan2 | (inf1 & exp2 == '0) | (inf2 & exp1 == '0);	// Zero * inf
	assign mul_exp = $signed({2'b00, exp1}) + $signed({2'b00, exp2})
		- (EXP_WIDTH + 2)'(EXP_BIAS);

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			s1_op <= OP_NOP;
			{s1_sig_large, s1_sig_small, s1_exp_large, s1_shift, s1_sign_large, s1_subtract,
				s1_result_negate, s1_mul_a, s1_mul_b, s1_mul_exp, s1_mul_sign,
				s1_is_nan, s1_is_inf} <= '0;
		end
		else
		begin
			s1_op <= operation_i;
			s1_sig_large <= swap ? sig2 : sig1;
			s1_sig_small <= swap ? sig1 : sig2;
			s1_exp_large <= swap ? exp2 : exp1;
			s1_shift <= shift_sat;
			s1_sign_large <= swap ? operand2_i.f.sign : operand1_i.f.sign;	// Raw sign
			s1_result_negate <= swap & subtract_op;	// Op2 won, its sign was flipped
			s1_subtract <= operand1_i.f.sign ^ eff_sign2;
			s1_mul_a <= (operation_i == OP_IMUL) ? operand1_i.i : {8'h00, mant1};
			s1_mul_b <= (operation_i == OP_IMUL) ? operand2_i.i : {8'h00, mant2};
			s1_mul_exp <= mul_exp;
			s1_mul_sign <= operand1_i.f.sign ^ operand2_i.f.sign;
			s1_is_nan <= add_like ? add_nan : (operation_i == OP_FMUL) & mul_nan;
			s1_is_inf <= (add_like || operation_i == OP_FMUL) & (inf1 | inf2);
		end
	end

	// Opcode is the only strobe, so it must always be driven
	op_known: assert property (@(posedge clk) disable iff (reset) !$isunknown(operation_i))
		else $error("operation_i is unknown after reset");

endmodule

`default_nettype wire

// ==== rtl/fp_alu_pkg.sv ====
// Shared definitions for the scalar arithmetic pipeline
// Opcodes, single-precision field layout, operand views and special values
`default_nettype none

package fp_alu_pkg;

	// Operation codes, NOP marks an idle slot
	typedef enum logic [5:0] {
		OP_NOP  = 6'h00,
		OP_IMUL = 6'h07,
		OP_FADD = 6'h20,
		OP_FSUB = 6'h21,
		OP_FMUL = 6'h22,
		OP_FGTR = 6'h2c,
		OP_FLT  = 6'h2d,
		OP_FGTE = 6'h2e,
		OP_FLTE = 6'h2f
	} alu_op_t;

	localparam int EXP_WIDTH = 8;
	localparam int SIG_WIDTH = 23;	// Stored fraction bits
	localparam int WORD_WIDTH = 32;
	localparam int EXP_BIAS = 127;

	// Zero carry bit, hidden bit, fraction, two guard bits
	localparam int ALIGN_WIDTH = 27;

	// Largest alignment shift, empties the significand
	localparam logic [4:0] ALIGN_SHIFT_MAX = 5'd26;

	typedef struct packed {
		logic sign;
		logic [EXP_WIDTH - 1:0] exponent;
		logic [SIG_WIDTH - 1:0] significand;
	} float_fields_t;

	// Float path reads fields, integer multiply reads the raw word
	typedef union packed {
		float_fields_t f;
		logic [WORD_WIDTH - 1:0] i;
	} operand_word_t;

	localparam logic [EXP_WIDTH - 1:0] EXP_SPECIAL = '1;	// Inf and NaN exponent
	localparam logic [WORD_WIDTH - 1:0] QNAN_WORD = '1;

	// Comparisons run through the adder as a subtraction
	function automatic logic is_compare_op(alu_op_t op);
		return op inside {OP_FGTR, OP_FLT, OP_FGTE, OP_FLTE};
	endfunction

endpackage

`default_nettype wire
